// File: list.f
verilog/rv_pkg.sv
verilog/rv_decoder.sv
verilog/reg_file.sv
verilog/rv_alu.sv
verilog/lsu.sv
verilog/rv_core.sv
verification/rv_checker.sv
verification/tb_top.sv

// File: run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f list.f -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -qx "No errors" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: verification/tb_top.sv
`timescale 1ns/100ps

module tb_top;
  import rv_pkg::*;

  localparam int MEM_WORDS = 256;
  localparam int PROG_LEN = 200;
  localparam int HALT_TIMEOUT = 2000;
  localparam int DATA_BASE = 256;
  localparam word_t ECALL_WORD = 32'h00000073;

  logic clk;
  logic rst;
  word_t imem_addr;
  word_t imem_data;
  dmem_req_t dmem_req;
  word_t dmem_rdata;
  logic halt;
  retire_t trace;
  word_t imem [MEM_WORDS];
  word_t dmem [MEM_WORDS];
  integer seed;
  int errors;
  int checks;
  int wait_cycles;
  logic timed_out;

  function automatic int pick(input int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % n);
  endfunction

  function automatic word_t r_type(input logic [6:0] f7, input reg_idx_t rs2,
                                   input reg_idx_t rs1, input logic [2:0] f3,
                                   input reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, OP_OP};
  endfunction

  function automatic word_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
                                   input logic [2:0] f3, input reg_idx_t rd,
                                   input opcode_e op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t s_type(input logic [11:0] imm, input reg_idx_t rs2,
                                   input reg_idx_t rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
  endfunction

  function automatic word_t b_type(input logic [12:0] imm, input reg_idx_t rs2,
                                   input reg_idx_t rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
  endfunction

  function automatic word_t j_type(input logic [20:0] imm, input reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
  endfunction

  function automatic word_t u_type(input logic [19:0] imm, input reg_idx_t rd,
                                   input opcode_e op);
    return {imm, rd, op};
  endfunction

  // every bit of the word index shows up in the initial data
  function automatic word_t fill_word(input logic [7:0] idx);
    return {idx ^ 8'ha5, idx, ~idx, idx ^ 8'h3c};
  endfunction

  task automatic build_program();
    int idx;
    int kind;
    int k;
    int size;
    logic [2:0] f3;
    logic [11:0] off;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i] = ECALL_WORD;
    end
    // x31 holds the data base and the jalr base and is never a random destination
    imem[0] = i_type(12'(DATA_BASE), 5'd0, 3'b000, 5'd31, OP_OP_IMM);
    idx = 1;
    while (idx < PROG_LEN - 1) begin
      kind = pick(16);
      rd = reg_idx_t'(pick(31));
      rs1 = reg_idx_t'(pick(32));
      rs2 = reg_idx_t'(pick(32));
      f3 = 3'(pick(8));
      k = 1 + pick(8);
      if (idx + k > PROG_LEN - 1) begin
        k = PROG_LEN - 1 - idx;
      end
      // size-aligned offset into a small window so loads meet earlier stores
      size = pick(3);
      off = 12'(4 * pick(16));
      if (size == 0) begin
        off = off + 12'(pick(4));
      end else if (size == 1) begin
        off = off + 12'(2 * pick(2));
      end
      case (kind)
        0, 1, 2: imem[idx] = i_type(12'($random(seed)), rs1, 3'b000, rd, OP_OP_IMM);
        3: imem[idx] = u_type(20'($random(seed)), rd, OP_LUI);
        4: imem[idx] = u_type(20'($random(seed)), rd, OP_AUIPC);
        5, 6, 7: begin
          imem[idx] = r_type(((f3 == 3'b000 || f3 == 3'b101) && pick(2) == 1) ?
                             7'b0100000 : 7'b0000000, rs2, rs1, f3, rd);
        end
        8: begin
          imem[idx] = i_type({(f3[2] && pick(2) == 1) ? 7'b0100000 : 7'b0000000, rs2},
                             rs1, f3[2] ? 3'b101 : 3'b001, rd, OP_OP_IMM);
        end
        9: begin
          f3 = (f3 == 3'b000 || f3 == 3'b001 || f3 == 3'b101) ? 3'b111 : f3;
          imem[idx] = i_type(12'($random(seed)), rs1, f3, rd, OP_OP_IMM);
        end
        10, 11: imem[idx] = s_type(off, rs2, 5'd31, 3'(size));
        12, 13: begin
          f3 = 3'(size) | ((size < 2 && pick(2) == 1) ? 3'b100 : 3'b000);
          imem[idx] = i_type(off, 5'd31, f3, rd, OP_LOAD);
        end
        14: begin
          f3 = (f3 == 3'b010 || f3 == 3'b011) ? f3 ^ 3'b110 : f3;
          imem[idx] = b_type(13'(4 * k), rs2, rs1, f3);
        end
        default: begin
          if (pick(2) == 0) begin
            imem[idx] = j_type(21'(4 * k), rd);
          end else begin
            // same forward target as jal, reached through the data base register
            imem[idx] = i_type(12'(4 * (idx + k) - DATA_BASE), 5'd31, 3'b000, rd, OP_JALR);
          end
        end
      endcase
      idx++;
    end
  endtask

  rv_core #(
    .reset_pc ('0)
  ) dut0 (
    .clk        (clk),
    .rst        (rst),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata),
    .halt       (halt),
    .trace      (trace)
  );

  rv_checker chk0 (
    .clk       (clk),
    .rst       (rst),
    .imem_addr (imem_addr),
    .trace     (trace),
    .dmem_req  (dmem_req),
    .halt      (halt),
    .prog      (imem),
    .data_init (dmem),
    .errors    (errors),
    .checks    (checks)
  );

  assign imem_data = imem[imem_addr[9:2]];
  assign dmem_rdata = dmem[dmem_req.addr[9:2]];

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        dmem[i] <= fill_word(8'(i));
      end
    end else begin
      for (int j = 0; j < 4; j++) begin
        if (dmem_req.be[j]) begin
          dmem[dmem_req.addr[9:2]][8*j +: 8] <= dmem_req.wdata[8*j +: 8];
        end
      end
    end
  end

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  initial begin
    seed = 68;
    rst = 1'b1;
    timed_out = 1'b0;
    wait_cycles = 0;
    build_program();
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    while (!halt && wait_cycles < HALT_TIMEOUT) begin
      @(negedge clk);
      wait_cycles++;
    end
    if (!halt) begin
      timed_out = 1'b1;
      $display("processor never halted within %0d cycles", HALT_TIMEOUT);
    end else begin
      // a few more cycles to see the core stay parked
      repeat (4) @(negedge clk);
    end
    // let the checker finish its last comparison
    @(posedge clk);
    $display("%0d instructions checked, %0d errors", checks, errors);
    if (timed_out || errors != 0) begin
      $display("Errors found");
    end else begin
      $display("No errors");
    end
    $finish;
  end

endmodule

// File: verification/rv_checker.sv
`timescale 1ns/100ps

module rv_checker (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::word_t     imem_addr,
  input  rv_pkg::retire_t   trace,
  input  rv_pkg::dmem_req_t dmem_req,
  input  logic              halt,
  input  rv_pkg::word_t     prog [256],
  input  rv_pkg::word_t     data_init [256],
  output int                errors,
  output int                checks
);
  import rv_pkg::*;

  localparam word_t ECALL_WORD = 32'h00000073;

  word_t shadow_regs [NUM_REGS];
  word_t shadow_mem [256];
  word_t shadow_pc;
  logic shadow_halted;
  retire_t exp_rec;
  dmem_req_t exp_st;
  word_t exp_npc;
  word_t lane_mask;

  function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                    input word_t x, input word_t y);
    word_t r;
    case (f3)
      3'b000:  r = alt ? x - y : x + y;
      3'b001:  r = x << y[4:0];
      3'b010:  r = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
      3'b011:  r = (x < y) ? 32'd1 : 32'd0;
      3'b100:  r = x ^ y;
      3'b101: begin
        if (alt) begin
          r = $signed(x) >>> y[4:0];
        end else begin
          r = x >> y[4:0];
        end
      end
      3'b110:  r = x | y;
      default: r = x & y;
    endcase
    return r;
  endfunction

  function automatic logic branch_ref(input logic [2:0] f3, input word_t x, input word_t y);
    case (f3)
      3'b000:  return x == y;
      3'b001:  return x != y;
      3'b100:  return $signed(x) < $signed(y);
      3'b101:  return $signed(x) >= $signed(y);
      3'b110:  return x < y;
      3'b111:  return x >= y;
      default: return 1'b0;
    endcase
  endfunction

  function automatic word_t byte_mask(input logic [3:0] be);
    return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
  endfunction

  // architectural model of one instruction
  function automatic retire_t ref_step(input word_t pc, input word_t insn,
                                       output dmem_req_t st, output word_t npc);
    retire_t r;
    word_t a;
    word_t b;
    word_t imm_i;
    word_t imm_s;
    word_t ea;
    word_t w;
    logic [2:0] f3;
    a = shadow_regs[insn[19:15]];
    b = shadow_regs[insn[24:20]];
    f3 = insn[14:12];
    imm_i = {{20{insn[31]}}, insn[31:20]};
    imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
    r = '0;
    st = '0;
    npc = pc + 32'd4;
    r.valid = 1'b1;
    r.pc = pc;
    r.insn = insn;
    r.rd = insn[11:7];
    case (insn[6:0])
      OP_LUI: begin
        r.rd_we = 1'b1;
        r.rd_data = {insn[31:12], 12'b0};
      end
      OP_AUIPC: begin
        r.rd_we = 1'b1;
        r.rd_data = pc + {insn[31:12], 12'b0};
      end
      OP_JAL: begin
        r.rd_we = 1'b1;
        r.rd_data = pc + 32'd4;
        npc = pc + {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
      end
      OP_JALR: begin
        r.rd_we = 1'b1;
        r.rd_data = pc + 32'd4;
        npc = (a + imm_i) & ~32'd1;
      end
      OP_BRANCH: begin
        if (branch_ref(f3, a, b)) begin
          npc = pc + {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
        end
      end
      OP_LOAD: begin
        ea = a + imm_i;
        w = shadow_mem[ea[9:2]] >> {ea[1:0], 3'b000};
        r.rd_we = 1'b1;
        case (f3)
          3'b000:  r.rd_data = {{24{w[7]}}, w[7:0]};
          3'b001:  r.rd_data = {{16{w[15]}}, w[15:0]};
          3'b100:  r.rd_data = {24'b0, w[7:0]};
          3'b101:  r.rd_data = {16'b0, w[15:0]};
          default: r.rd_data = w;
        endcase
      end
      OP_STORE: begin
        ea = a + imm_s;
        st.addr = {ea[31:2], 2'b00};
        // data replicated over all lanes and the enables pick the valid ones
        case (f3)
          3'b000: begin
            st.be = 4'b0001 << ea[1:0];
            st.wdata = {4{b[7:0]}};
          end
          3'b001: begin
            st.be = 4'b0011 << ea[1:0];
            st.wdata = {2{b[15:0]}};
          end
          default: begin
            st.be = 4'b1111;
            st.wdata = b;
          end
        endcase
      end
      OP_OP_IMM: begin
        r.rd_we = 1'b1;
        r.rd_data = alu_ref(f3, insn[30] & (f3 == 3'b101), a, imm_i);
      end
      OP_OP: begin
        if (insn[31:25] == 7'b0000000 || insn[31:25] == 7'b0100000) begin
          r.rd_we = 1'b1;
          r.rd_data = alu_ref(f3, insn[30], a, b);
        end
      end
      default: begin
        // ecall, fence and unknown opcodes change no state
        r.rd_we = 1'b0;
      end
    endcase
    return r;
  endfunction

  task automatic expect_word(input string what, input word_t got, input word_t want);
    if (got !== want) begin
      errors++;
      $display("ERR %0t: pc %h %s is %h, expected %h", $time, exp_rec.pc, what, got, want);
    end
  endtask

  initial begin
    errors = 0;
    checks = 0;
  end

  // compare mid-cycle once every combinational output has settled
  always @(negedge clk) begin
    if (rst) begin
      shadow_pc = '0;
      shadow_halted = 1'b0;
      for (int j = 0; j < NUM_REGS; j++) begin
        shadow_regs[j] = '0;
      end
      for (int j = 0; j < 256; j++) begin
        shadow_mem[j] = data_init[j];
      end
      if (halt || trace.valid || dmem_req.be != 4'b0000) begin
        errors++;
        $display("ERR %0t: halt, trace valid or byte enable active during reset", $time);
      end
    end else if (shadow_halted) begin
      if (!halt || trace.valid || dmem_req.be != 4'b0000) begin
        errors++;
        $display("ERR %0t: core left the halted state or stored after ecall", $time);
      end
    end else begin
      checks++;
      exp_rec = ref_step(shadow_pc, prog[shadow_pc[9:2]], exp_st, exp_npc);
      expect_word("trace valid", {31'b0, trace.valid}, 32'd1);
      expect_word("trace pc", trace.pc, exp_rec.pc);
      expect_word("fetch address", imem_addr, exp_rec.pc);
      expect_word("trace insn", trace.insn, exp_rec.insn);
      expect_word("rd write enable", {31'b0, trace.rd_we}, {31'b0, exp_rec.rd_we});
      if (exp_rec.rd_we) begin
        expect_word("rd index", {27'b0, trace.rd}, {27'b0, exp_rec.rd});
        expect_word("rd data", trace.rd_data, exp_rec.rd_data);
      end
      expect_word("halt", {31'b0, halt}, {31'b0, exp_rec.insn == ECALL_WORD});
      expect_word("byte enables", {28'b0, dmem_req.be}, {28'b0, exp_st.be});
      if (exp_st.be != 4'b0000) begin
        lane_mask = byte_mask(exp_st.be);
        expect_word("store address", dmem_req.addr, exp_st.addr);
        expect_word("store data", dmem_req.wdata & lane_mask, exp_st.wdata & lane_mask);
      end
      // advance the shadow state and leave x0 at zero
      if (exp_rec.rd_we && exp_rec.rd != '0) begin
        shadow_regs[exp_rec.rd] = exp_rec.rd_data;
      end
      for (int j = 0; j < 4; j++) begin
        if (exp_st.be[j]) begin
          shadow_mem[exp_st.addr[9:2]][8*j +: 8] = exp_st.wdata[8*j +: 8];
        end
      end
      if (exp_rec.insn == ECALL_WORD) begin
        shadow_halted = 1'b1;
      end
      shadow_pc = exp_npc;
    end
  end

endmodule

// File: verilog/rv_core.sv
`timescale 1ns/100ps

module rv_core #(
  parameter rv_pkg::word_t reset_pc = '0
) (
  input  logic              clk,
  input  logic              rst,
  output rv_pkg::word_t     imem_addr,
  input  rv_pkg::word_t     imem_data,
  output rv_pkg::dmem_req_t dmem_req,
  input  rv_pkg::word_t     dmem_rdata,
  output logic              halt,
  output rv_pkg::retire_t   trace
);
  import rv_pkg::*;

  word_t pc;
  word_t pc_next;
  word_t pc_plus_4;
  word_t pc_plus_imm;
  logic halted_q;
  decoded_t dec;
  word_t rs1_data;
  word_t rs2_data;
  word_t alu_b;
  word_t alu_result;
  logic branch_taken;
  word_t load_value;
  dmem_req_t lsu_req;
  word_t wb_data;
  logic rf_we;
  logic store_en;

  rv_decoder u_decoder (
    .insn (imem_data),
    .dec  (dec)
  );

  reg_file u_reg_file (
    .clk      (clk),
    .rst      (rst),
    .rs1      (dec.rs1),
    .rs2      (dec.rs2),
    .rd       (dec.rd),
    .we       (rf_we),
    .rd_data  (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  assign alu_b = dec.alu_use_imm ? dec.imm : rs2_data;

  rv_alu u_alu (
    .op           (dec.alu_op),
    .a            (rs1_data),
    .b            (alu_b),
    .funct3       (dec.funct3),
    .result       (alu_result),
    .branch_taken (branch_taken)
  );

  lsu u_lsu (
    .dec        (dec),
    .addr       (alu_result),
    .store_data (rs2_data),
    .dmem_rdata (dmem_rdata),
    .dmem_req   (lsu_req),
    .load_value (load_value)
  );

  assign pc_plus_4 = pc + 32'd4;
  assign pc_plus_imm = pc + dec.imm;

  // ecall holds the pc, so halt stays up until reset
  assign halt = ~rst & (dec.is_ecall | halted_q);
  assign store_en = ~rst & ~halt;
  assign rf_we = dec.reg_write & ~halt;

  always_comb begin
    if (halt) begin
      pc_next = pc;
    end else if (dec.is_jalr) begin
      pc_next = {alu_result[XLEN-1:1], 1'b0};
    end else if (dec.is_jal || (dec.is_branch && branch_taken)) begin
      pc_next = pc_plus_imm;
    end else begin
      pc_next = pc_plus_4;
    end
  end

  always_comb begin
    if (dec.is_load) begin
      wb_data = load_value;
    end else if (dec.is_jal || dec.is_jalr) begin
      wb_data = pc_plus_4;
    end else if (dec.is_auipc) begin
      wb_data = pc_plus_imm;
    end else begin
      wb_data = alu_result;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= reset_pc;
      halted_q <= 1'b0;
    end else begin
      pc <= pc_next;
      halted_q <= halt;
    end
  end

  assign imem_addr = pc;

  always_comb begin
    dmem_req = lsu_req;
    dmem_req.be = store_en ? lsu_req.be : 4'b0000;
  end

  // the record describes the instruction presented this cycle
  assign trace.valid = ~rst & ~halted_q;
  assign trace.pc = pc;
  assign trace.insn = imem_data;
  assign trace.rd_we = rf_we;
  assign trace.rd = dec.rd;
  assign trace.rd_data = wb_data;

  // fetch addresses stay word-aligned across every jump and branch target
  pc_align_a: assert property (@(posedge clk) disable iff (rst) imem_addr[1:0] == 2'b00)
    else $error("misaligned fetch address %h", imem_addr);

endmodule

// File: verilog/lsu.sv
`timescale 1ns/100ps

module lsu (
  input  rv_pkg::decoded_t  dec,
  input  rv_pkg::word_t     addr,
  input  rv_pkg::word_t     store_data,
  input  rv_pkg::word_t     dmem_rdata,
  output rv_pkg::dmem_req_t dmem_req,
  output rv_pkg::word_t     load_value
);
  import rv_pkg::*;

  logic [1:0] offset;
  logic [4:0] lane_shift;
  word_t rdata_shifted;
  logic [3:0] be_base;

  assign offset = addr[1:0];
  assign lane_shift = {offset, 3'b000};

  // size from funct3[1:0]: byte, half, word
  always_comb begin
    case (dec.funct3[1:0])
      2'b00:   be_base = 4'b0001;
      2'b01:   be_base = 4'b0011;
      default: be_base = 4'b1111;
    endcase
  end

  always_comb begin
    dmem_req.addr = {addr[XLEN-1:2], 2'b00};
    dmem_req.wdata = store_data << lane_shift;
    dmem_req.be = dec.is_store ? (be_base << offset) : 4'b0000;
  end

  // bring the addressed lane down to bit 0
  assign rdata_shifted = dmem_rdata >> lane_shift;

  always_comb begin
    case (dec.funct3)
      3'b000: begin
        load_value = {{24{rdata_shifted[7]}}, rdata_shifted[7:0]};
      end
      3'b001: begin
        load_value = {{16{rdata_shifted[15]}}, rdata_shifted[15:0]};
      end
      3'b100: begin
        load_value = {24'b0, rdata_shifted[7:0]};
      end
      3'b101: begin
        load_value = {16'b0, rdata_shifted[15:0]};
      end
      default: begin
        load_value = dmem_rdata;
      end
    endcase
  end

endmodule

// File: verilog/rv_alu.sv
`timescale 1ns/100ps

module rv_alu (
  input  rv_pkg::alu_op_e op,
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  input  logic [2:0]      funct3,
  output rv_pkg::word_t   result,
  output logic            branch_taken
);
  import rv_pkg::*;

  logic sub_sel;
  word_t b_adj;
  word_t sum;
  logic [4:0] shamt;
  logic eq;
  logic lt;
  logic ltu;

  // single adder, subtract via inverted operand and carry in
  assign sub_sel = (op == ALU_SUB);
  assign b_adj = sub_sel ? ~b : b;
  assign sum = a + b_adj + {{(XLEN-1){1'b0}}, sub_sel};

  assign shamt = b[4:0];
  assign eq = (a == b);
  assign lt = ($signed(a) < $signed(b));
  assign ltu = (a < b);

  always_comb begin
    case (op)
      ALU_ADD, ALU_SUB: result = sum;
      ALU_SLL:    result = a << shamt;
      ALU_SLT:    result = {{(XLEN-1){1'b0}}, lt};
      ALU_SLTU:   result = {{(XLEN-1){1'b0}}, ltu};
      ALU_XOR:    result = a ^ b;
      ALU_SRL:    result = a >> shamt;
      ALU_SRA:    result = $signed(a) >>> shamt;
      ALU_OR:     result = a | b;
      ALU_AND:    result = a & b;
      ALU_PASS_B: result = b;
      default:    result = sum;
    endcase
  end

  // branch condition from funct3
  always_comb begin
    case (funct3)
      3'b000:  branch_taken = eq;
      3'b001:  branch_taken = ~eq;
      3'b100:  branch_taken = lt;
      3'b101:  branch_taken = ~lt;
      3'b110:  branch_taken = ltu;
      3'b111:  branch_taken = ~ltu;
      default: branch_taken = 1'b0;
    endcase
  end

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/100ps

module reg_file (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  input  rv_pkg::reg_idx_t rd,
  input  logic             we,
  input  rv_pkg::word_t    rd_data,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data
);
  import rv_pkg::*;

  word_t regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  // read-before-write, x0 hardwired to zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  // whatever the core writes back, x0 storage must stay clear
  x0_zero_a: assert property (@(posedge clk) disable iff (rst) regs[0] == '0)
    else $error("x0 holds a non-zero value");

endmodule

// File: verilog/rv_decoder.sv
`timescale 1ns/100ps

module rv_decoder (
  input  rv_pkg::word_t    insn,
  output rv_pkg::decoded_t dec
);
  import rv_pkg::*;

  word_t imm_i;
  word_t imm_s;
  word_t imm_b;
  word_t imm_j;
  word_t imm_u;
  logic [6:0] funct7;

  // funct3 plus the alternate bit (insn[30]) pick the ALU function
  function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  assign funct7 = insn[31:25];

  // immediate formats, all sign-extended from bit 31
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  always_comb begin
    dec = '0;
    dec.opcode = opcode_e'(insn[6:0]);
    dec.funct3 = insn[14:12];
    dec.rs1 = insn[19:15];
    dec.rs2 = insn[24:20];
    dec.rd = insn[11:7];
    dec.alu_op = ALU_ADD;
    case (dec.opcode)
      OP_LUI: begin
        dec.reg_write = 1'b1;
        dec.alu_use_imm = 1'b1;
        dec.alu_op = ALU_PASS_B;
        dec.imm = imm_u;
      end
      OP_AUIPC: begin
        dec.reg_write = 1'b1;
        dec.is_auipc = 1'b1;
        dec.imm = imm_u;
      end
      OP_JAL: begin
        dec.reg_write = 1'b1;
        dec.is_jal = 1'b1;
        dec.imm = imm_j;
      end
      OP_JALR: begin
        dec.reg_write = 1'b1;
        dec.is_jalr = 1'b1;
        dec.alu_use_imm = 1'b1;
        dec.imm = imm_i;
      end
      OP_BRANCH: begin
        dec.is_branch = 1'b1;
        dec.alu_op = ALU_SUB;
        dec.imm = imm_b;
      end
      OP_LOAD: begin
        dec.reg_write = 1'b1;
        dec.is_load = 1'b1;
        dec.alu_use_imm = 1'b1;
        dec.imm = imm_i;
      end
      OP_STORE: begin
        dec.is_store = 1'b1;
        dec.alu_use_imm = 1'b1;
        dec.imm = imm_s;
      end
      OP_OP_IMM: begin
        dec.reg_write = 1'b1;
        dec.alu_use_imm = 1'b1;
        dec.imm = imm_i;
        // only srai uses the alternate bit; addi must never become a subtract
        dec.alu_op = alu_sel(insn[14:12], insn[30] & (insn[14:12] == 3'b101));
      end
      OP_OP: begin
        // other funct7 values (M extension) fall through as no-ops
        if (funct7 == FUNCT7_BASE || funct7 == FUNCT7_ALT) begin
          dec.reg_write = 1'b1;
          dec.alu_op = alu_sel(insn[14:12], insn[30]);
        end
      end
      OP_SYSTEM: begin
        dec.is_ecall = (insn[31:7] == '0);
      end
      OP_MISC_MEM: begin
        // fence has nothing to order in this core
        dec.imm = imm_i;
      end
      default: begin
        dec.imm = '0;
      end
    endcase
  end

endmodule

// File: verilog/rv_pkg.sv
package rv_pkg;

  // architectural widths
  localparam int XLEN = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS = 1 << REG_ADDR_W;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [REG_ADDR_W-1:0] reg_idx_t;

  // funct7 values accepted for register-register operations
  localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
  localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

  // rv32 major opcodes
  typedef enum logic [6:0] {
    OP_LOAD     = 7'b0000011,
    OP_MISC_MEM = 7'b0001111,
    OP_OP_IMM   = 7'b0010011,
    OP_AUIPC    = 7'b0010111,
    OP_STORE    = 7'b0100011,
    OP_OP       = 7'b0110011,
    OP_LUI      = 7'b0110111,
    OP_BRANCH   = 7'b1100011,
    OP_JALR     = 7'b1100111,
    OP_JAL      = 7'b1101111,
    OP_SYSTEM   = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  typedef struct packed {
    opcode_e  opcode;
    logic [2:0] funct3;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    word_t    imm;
    alu_op_e  alu_op;
    logic     alu_use_imm;
    logic     reg_write;
    logic     is_load;
    logic     is_store;
    logic     is_branch;
    logic     is_jal;
    logic     is_jalr;
    logic     is_auipc;
    logic     is_ecall;
  } decoded_t;

  typedef struct packed {
    word_t      addr;
    word_t      wdata;
    logic [3:0] be;
  } dmem_req_t;

  typedef struct packed {
    logic     valid;
    word_t    pc;
    word_t    insn;
    logic     rd_we;
    reg_idx_t rd;
    word_t    rd_data;
  } retire_t;

endpackage
